// File: design/cache_perf_pkg.sv
package cache_perf_pkg;

	// word widths
	// --------------------------------------------------
	localparam int CMD_W   = 32;	// command and return word
	localparam int CNT_W   = 64;	// event counters and trace stamp
	localparam int SEL_W   = 4;	// return select field
	localparam int SHIFT_W = 4;	// sampling shift field

	// return select codes, one per readable value
	typedef enum logic [SEL_W-1:0] {
		SEL_HIT_LO    = 4'd0,
		SEL_HIT_HI    = 4'd1,
		SEL_MISS_LO   = 4'd2,
		SEL_MISS_HI   = 4'd3,
		SEL_WB_LO     = 4'd4,
		SEL_WB_HI     = 4'd5,
		SEL_REFPC     = 4'd6,	// head record pc
		SEL_INTERVAL  = 4'd7,	// head record reuse interval
		SEL_USED      = 4'd8,	// records waiting in the buffer
		SEL_COUNT     = 4'd9,	// accepted requests, low word
		SEL_REMAINING = 4'd10,	// free tag table entries
		SEL_TRACE_LO  = 4'd11,
		SEL_TRACE_HI  = 4'd12,
		SEL_TARGET    = 4'd13,	// head record tag
		SEL_SYSID     = 4'd14,	// reads zero
		SEL_BUF_FULL  = 4'd15
	} sel_e;

	// command word layout
	// --------------------------------------------------
	typedef struct packed {
		logic [5:0]         rsvd_hi;	// bits 31..26
		logic               pop;		// bit 25, rising edge drops head
		logic               count_en;	// bit 24, event counter enable
		logic [11:0]        rsvd_mid;	// bits 23..12
		logic [SHIFT_W-1:0] shift;		// bits 11..8, sample every 2^shift
		logic [3:0]         rsvd_lo;	// bits 7..4
		sel_e               sel;		// bits 3..0
	} comm_t;

	// one measured reuse
	typedef struct packed {
		logic [CMD_W-1:0] pc;			// pc of the sampled reference
		logic [CMD_W-1:0] tag;			// zero-extended cache tag
		logic [CMD_W-1:0] interval;		// requests between the two references
		logic [CNT_W-1:0] trace;		// request count at reuse
	} reuse_rec_t;

	// sampler status seen by the controller
	typedef struct packed {
		logic [CMD_W-1:0] used;
		logic [CMD_W-1:0] count;
		logic [CMD_W-1:0] remaining;
	} sampler_stat_t;

endpackage

// File: design/reuse_interval_sampler.sv
`timescale 1ns/10ps

module reuse_interval_sampler #(
	parameter int TAG_W       = 20,
	parameter int TABLE_DEPTH = 4,
	parameter int BUF_DEPTH   = 8
)(
	input  logic                                clock_i,
	input  logic                                resetn_i,
	input  logic                                req_i,		// one request per cycle
	input  logic [cache_perf_pkg::CMD_W-1:0]    pc_ref_i,
	input  logic [TAG_W-1:0]                    tag_ref_i,
	input  logic [cache_perf_pkg::SHIFT_W-1:0]  shift_i,
	input  logic                                pop_i,		// level, edge taken here
	output cache_perf_pkg::reuse_rec_t          head_o,
	output cache_perf_pkg::sampler_stat_t       stat_o,
	output logic                                buf_full_o,
	output logic                                table_full_o
);

	import cache_perf_pkg::*;

	localparam int IDX_W  = (TABLE_DEPTH > 1) ? $clog2(TABLE_DEPTH) : 1;
	localparam int TCNT_W = $clog2(TABLE_DEPTH + 1);
	localparam int PTR_W  = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
	localparam int OCC_W  = $clog2(BUF_DEPTH + 1);

	// request stream state
	logic [CNT_W-1:0]       req_cnt;			// accepted requests so far
	logic [CNT_W-1:0]       sample_mask;
	logic                   accept;				// unstalled request this cycle
	logic                   sample_due;

	// tag table
	logic [TABLE_DEPTH-1:0] tbl_valid;
	logic [TAG_W-1:0]       tbl_tag   [TABLE_DEPTH];
	logic [CMD_W-1:0]       tbl_pc    [TABLE_DEPTH];
	logic [CNT_W-1:0]       tbl_start [TABLE_DEPTH];
	logic [TABLE_DEPTH-1:0] match_vec;
	logic [TABLE_DEPTH-1:0] free_vec;
	logic                   match_any;
	logic [IDX_W-1:0]       match_idx;
	logic [IDX_W-1:0]       free_idx;
	logic                   install;
	logic [TCNT_W-1:0]      tbl_used;

	// record buffer
	reuse_rec_t             buf_mem [BUF_DEPTH];
	reuse_rec_t             new_rec;
	logic [PTR_W-1:0]       wr_ptr;
	logic [PTR_W-1:0]       rd_ptr;
	logic [OCC_W-1:0]       occ;
	logic                   push;
	logic                   pop_q;
	logic                   pop_do;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		next_ptr = (ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : ptr + 1'b1;	// wrap at depth
	endfunction

	// request acceptance and sampling
	// --------------------------------------------------
	assign buf_full_o   = (occ == OCC_W'(BUF_DEPTH));
	assign table_full_o = &tbl_valid;
	assign accept       = req_i && !(buf_full_o || table_full_o);	// stalled req dropped
	assign sample_mask  = ~({CNT_W{1'b1}} << shift_i);			// low shift bits
	assign sample_due   = ((req_cnt & sample_mask) == '0);

	// parallel tag compare, lowest index wins
	always_comb begin
		match_any = 1'b0;
		match_idx = '0;
		for (int i = TABLE_DEPTH - 1; i >= 0; i--) begin
			match_vec[i] = tbl_valid[i] && (tbl_tag[i] == tag_ref_i);
			if (match_vec[i]) begin
				match_any = 1'b1;
				match_idx = IDX_W'(i);
			end
		end
	end

	// a matched entry frees this cycle, so it may be reused at once
	assign free_vec = ~tbl_valid | match_vec;

	always_comb begin
		free_idx = '0;
		for (int i = TABLE_DEPTH - 1; i >= 0; i--) begin
			if (free_vec[i])
				free_idx = IDX_W'(i);
		end
	end

	assign install = accept && sample_due;	// match checked first
	assign push    = accept && match_any;	// reuse measured

	always_comb begin
		tbl_used = '0;
		for (int i = 0; i < TABLE_DEPTH; i++) begin
			tbl_used = tbl_used + TCNT_W'(tbl_valid[i]);
		end
	end

	// table control
	// --------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			req_cnt   <= '0;
			tbl_valid <= '0;
		end else if (accept) begin
			req_cnt <= req_cnt + 1'b1;
			if (match_any)
				tbl_valid[match_idx] <= 1'b0;	// reuse closes the entry
			if (install)
				tbl_valid[free_idx] <= 1'b1;	// reinstall overrides the clear
		end
	end

	always_ff @(posedge clock_i) begin
		if (install) begin
			tbl_tag[free_idx]   <= tag_ref_i;
			tbl_pc[free_idx]    <= pc_ref_i;
			tbl_start[free_idx] <= req_cnt;	// count before increment
		end
	end

	// record buffer
	// --------------------------------------------------
	always_comb begin
		new_rec.pc       = tbl_pc[match_idx];
		new_rec.tag      = CMD_W'(tbl_tag[match_idx]);
		new_rec.interval = CMD_W'(req_cnt - tbl_start[match_idx]);
		new_rec.trace    = req_cnt;
	end

	assign pop_do = pop_i && !pop_q && (occ != '0);	// rising edge, ignored when empty

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			pop_q  <= 1'b0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			occ    <= '0;
		end else begin
			pop_q <= pop_i;
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop_do)
				rd_ptr <= next_ptr(rd_ptr);
			case ({push, pop_do})
				2'b10:   occ <= occ + 1'b1;
				2'b01:   occ <= occ - 1'b1;
				default: occ <= occ;		// none or both
			endcase
		end
	end

	always_ff @(posedge clock_i) begin
		if (push)
			buf_mem[wr_ptr] <= new_rec;
	end

	// head reads zero while the buffer is empty
	assign head_o = (occ != '0) ? buf_mem[rd_ptr] : '0;

	assign stat_o.used      = CMD_W'(occ);
	assign stat_o.count     = req_cnt[CMD_W-1:0];
	assign stat_o.remaining = CMD_W'(TABLE_DEPTH) - CMD_W'(tbl_used);

endmodule

// File: design/cache_perf_controller.sv
`timescale 1ns/10ps

module cache_perf_controller #(
	parameter int TAG_W       = 20,
	parameter int TABLE_DEPTH = 4,
	parameter int BUF_DEPTH   = 8
)(
	input  logic                              clock_i,
	input  logic                              resetn_i,
	input  cache_perf_pkg::comm_t             comm_i,		// software command word
	input  logic                              req_i,
	input  logic [cache_perf_pkg::CMD_W-1:0]  pc_ref_i,
	input  logic [TAG_W-1:0]                  tag_ref_i,
	input  logic                              hit_i,		// cache hit strobe
	input  logic                              miss_i,		// first miss strobe
	input  logic                              writeback_i,	// block written back
	output logic [cache_perf_pkg::CMD_W-1:0]  comm_o,		// registered return word
	output logic                              stall_o
);

	import cache_perf_pkg::*;

	localparam int N_EVT = 3;	// hit, miss, write-back

	logic [N_EVT-1:0]  evt_stb;
	logic [CNT_W-1:0]  evt_cnt [N_EVT];
	reuse_rec_t        head;
	sampler_stat_t     stat;
	logic              buf_full;
	logic              table_full;
	logic [CMD_W-1:0]  ret_word;

	// event counters
	// --------------------------------------------------
	assign evt_stb = {writeback_i, miss_i, hit_i};	// index 0 hit, 1 miss, 2 wb

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			for (int i = 0; i < N_EVT; i++)
				evt_cnt[i] <= '0;
		end else if (comm_i.count_en) begin
			for (int i = 0; i < N_EVT; i++) begin
				if (evt_stb[i])
					evt_cnt[i] <= evt_cnt[i] + 1'b1;
			end
		end
	end

	// return word select
	// --------------------------------------------------
	always_comb begin
		case (comm_i.sel)
			SEL_HIT_LO:    ret_word = evt_cnt[0][CMD_W-1:0];
			SEL_HIT_HI:    ret_word = evt_cnt[0][CNT_W-1:CMD_W];
			SEL_MISS_LO:   ret_word = evt_cnt[1][CMD_W-1:0];
			SEL_MISS_HI:   ret_word = evt_cnt[1][CNT_W-1:CMD_W];
			SEL_WB_LO:     ret_word = evt_cnt[2][CMD_W-1:0];
			SEL_WB_HI:     ret_word = evt_cnt[2][CNT_W-1:CMD_W];
			SEL_REFPC:     ret_word = head.pc;
			SEL_INTERVAL:  ret_word = head.interval;
			SEL_USED:      ret_word = stat.used;
			SEL_COUNT:     ret_word = stat.count;
			SEL_REMAINING: ret_word = stat.remaining;
			SEL_TRACE_LO:  ret_word = head.trace[CMD_W-1:0];
			SEL_TRACE_HI:  ret_word = head.trace[CNT_W-1:CMD_W];
			SEL_TARGET:    ret_word = head.tag;
			SEL_SYSID:     ret_word = '0;				// no system id in this build
			SEL_BUF_FULL:  ret_word = CMD_W'(buf_full);	// flag in bit 0
			default:       ret_word = '0;
		endcase
	end

	always_ff @(posedge clock_i) begin
		if (!resetn_i)
			comm_o <= '0;
		else
			comm_o <= ret_word;	// one cycle behind sel
	end

	// either full flag holds off the request source
	assign stall_o = buf_full | table_full;

	// reuse sampler
	// --------------------------------------------------
	reuse_interval_sampler #(
		.TAG_W       (TAG_W),
		.TABLE_DEPTH (TABLE_DEPTH),
		.BUF_DEPTH   (BUF_DEPTH)
	) u_sampler (
		.clock_i      (clock_i),
		.resetn_i     (resetn_i),
		.req_i        (req_i),
		.pc_ref_i     (pc_ref_i),
		.tag_ref_i    (tag_ref_i),
		.shift_i      (comm_i.shift),
		.pop_i        (comm_i.pop),
		.head_o       (head),
		.stat_o       (stat),
		.buf_full_o   (buf_full),
		.table_full_o (table_full)
	);

endmodule

// File: design/cache_monitor_top.sv
`timescale 1ns/10ps

module cache_monitor_top #(
	parameter int TAG_W       = 20,	// cache tag width
	parameter int TABLE_DEPTH = 4,	// sampled tags tracked at once
	parameter int BUF_DEPTH   = 8	// reuse records held
)(
	input  logic                              clock_i,
	input  logic                              resetn_i,
	input  cache_perf_pkg::comm_t             comm_i,
	input  logic                              req_i,
	input  logic [cache_perf_pkg::CMD_W-1:0]  pc_ref_i,
	input  logic [TAG_W-1:0]                  tag_ref_i,
	input  logic                              hit_i,
	input  logic                              miss_i,
	input  logic                              writeback_i,
	output logic [cache_perf_pkg::CMD_W-1:0]  comm_o,
	output logic                              stall_o		// hold off req_i while high
);

	// monitor core
	// --------------------------------------------------
	cache_perf_controller #(
		.TAG_W       (TAG_W),
		.TABLE_DEPTH (TABLE_DEPTH),
		.BUF_DEPTH   (BUF_DEPTH)
	) u_controller (
		.clock_i     (clock_i),
		.resetn_i    (resetn_i),
		.comm_i      (comm_i),
		.req_i       (req_i),
		.pc_ref_i    (pc_ref_i),
		.tag_ref_i   (tag_ref_i),
		.hit_i       (hit_i),
		.miss_i      (miss_i),
		.writeback_i (writeback_i),
		.comm_o      (comm_o),
		.stall_o     (stall_o)
	);

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 4,	// full clock period
	parameter int RESET_CYCLES = 3	// rising edges with reset held low
)(
	output logic clock_o,
	output logic resetn_o
);

	initial begin
		clock_o = 1'b0;
		forever #(PERIOD_NS / 2) clock_o = ~clock_o;	// 50 % duty
	end

	initial begin
		resetn_o = 1'b0;	// low from time zero
		repeat (RESET_CYCLES) @(posedge clock_o);
		resetn_o <= 1'b1;	// released on a rising edge
	end

endmodule

// File: tests/cache_monitor_sva.sv
`timescale 1ns/10ps

module cache_monitor_sva #(
	parameter int BUF_DEPTH = 8	// records held by the sampler
)(
	input logic        clock_i,
	input logic        resetn_i,
	input logic        count_en_i,
	input logic        stall_i,
	input logic [31:0] used_i,
	input logic [31:0] remaining_i,
	input logic [63:0] hit_cnt_i,
	input logic [63:0] miss_cnt_i,
	input logic [63:0] wb_cnt_i
);

	// stall follows a full buffer or a table with no free entry
	stall_is_or: assert property (@(posedge clock_i) disable iff (!resetn_i)
		stall_i == ((used_i == 32'(BUF_DEPTH)) || (remaining_i == '0)))
		else $error("stall_o differs from the buffer and table full state");

	// counters frozen while counting is off
	counters_hold: assert property (@(posedge clock_i) disable iff (!resetn_i)
		!count_en_i |=> $stable({hit_cnt_i, miss_cnt_i, wb_cnt_i}))
		else $error("event counter moved while counting was disabled");

	stall_low_after_reset: assert property (@(posedge clock_i) !resetn_i |=> !stall_i)
		else $error("stall_o high in the cycle after reset");

endmodule

bind cache_perf_controller cache_monitor_sva #(.BUF_DEPTH(BUF_DEPTH)) u_sva (
	.clock_i     (clock_i),
	.resetn_i    (resetn_i),
	.count_en_i  (comm_i.count_en),
	.stall_i     (stall_o),
	.used_i      (stat.used),
	.remaining_i (stat.remaining),
	.hit_cnt_i   (evt_cnt[0]),
	.miss_cnt_i  (evt_cnt[1]),
	.wb_cnt_i    (evt_cnt[2])
);

// File: tests/cache_monitor_tb.sv
`timescale 1ns/10ps

module cache_monitor_tb;

	import cache_perf_pkg::*;

	localparam int TAG_W       = 20;
	localparam int TABLE_DEPTH = 4;
	localparam int BUF_DEPTH   = 8;

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [31:0]      pc;
		logic [63:0]      start;	// request count at install
	} entry_t;

	logic             clock;
	logic             resetn;
	comm_t            comm;
	logic             req;
	logic [31:0]      pc_ref;
	logic [TAG_W-1:0] tag_ref;
	logic             hit;
	logic             miss;
	logic             writeback;
	logic [31:0]      comm_o;
	logic             stall_o;

	// reference model state
	// --------------------------------------------------
	comm_t            cur_comm;		// command applied by the next step
	logic [63:0]      model_cnt [3];	// hit, miss, wb
	logic [63:0]      req_cnt;
	logic             pop_q;
	entry_t           tbl_q [$];
	reuse_rec_t       rec_q [$];		// head at index 0
	logic [31:0]      lfsr_state;
	int               errors;
	int               checks;

	tb_clock_gen #(.PERIOD_NS(4), .RESET_CYCLES(3)) u_clock_gen (
		.clock_o  (clock),
		.resetn_o (resetn)
	);

	cache_monitor_top #(
		.TAG_W       (TAG_W),
		.TABLE_DEPTH (TABLE_DEPTH),
		.BUF_DEPTH   (BUF_DEPTH)
	) u_cache_monitor_top (
		.clock_i     (clock),
		.resetn_i    (resetn),
		.comm_i      (comm),
		.req_i       (req),
		.pc_ref_i    (pc_ref),
		.tag_ref_i   (tag_ref),
		.hit_i       (hit),
		.miss_i      (miss),
		.writeback_i (writeback),
		.comm_o      (comm_o),
		.stall_o     (stall_o)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);	// taps 32 22 2 1
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);	// one step per bit
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	function automatic logic model_stall();
		return (rec_q.size() == BUF_DEPTH) || (tbl_q.size() == TABLE_DEPTH);
	endfunction

	// return word the DUT should show for a select
	function automatic logic [31:0] expected_word(input sel_e sel);
		int         s;
		reuse_rec_t head;
		s    = int'(sel);
		head = (rec_q.size() != 0) ? rec_q[0] : '0;
		if (s <= 5)
			return model_cnt[s / 2][32 * (s % 2) +: 32];	// counter halves
		case (sel)
			SEL_REFPC:     return head.pc;
			SEL_INTERVAL:  return head.interval;
			SEL_USED:      return 32'(rec_q.size());
			SEL_COUNT:     return req_cnt[31:0];
			SEL_REMAINING: return 32'(TABLE_DEPTH - tbl_q.size());
			SEL_TRACE_LO:  return head.trace[31:0];
			SEL_TRACE_HI:  return head.trace[63:32];
			SEL_TARGET:    return head.tag;
			SEL_BUF_FULL:  return 32'(rec_q.size() == BUF_DEPTH);
			default:       return '0;	// system id
		endcase
	endfunction

	// model of one DUT edge
	task automatic model_edge(input logic r, input logic [31:0] pc,
			input logic [TAG_W-1:0] tag, input logic [2:0] evt);
		int          hit_idx;
		logic        pop_do;
		logic [63:0] mask;
		for (int i = 0; i < 3; i++)
			if (cur_comm.count_en && evt[i]) model_cnt[i]++;
		pop_do = cur_comm.pop && !pop_q && (rec_q.size() != 0);	// seen before push
		pop_q  = cur_comm.pop;
		if (r && !model_stall()) begin
			hit_idx = -1;
			foreach (tbl_q[i])
				if (tbl_q[i].tag == tag) hit_idx = i;
			if (hit_idx >= 0) begin
				rec_q.push_back('{pc: tbl_q[hit_idx].pc, tag: 32'(tbl_q[hit_idx].tag),
					interval: 32'(req_cnt - tbl_q[hit_idx].start), trace: req_cnt});
				tbl_q.delete(hit_idx);	// reuse closes the entry
			end
			mask = (64'd1 << cur_comm.shift) - 64'd1;
			if (((req_cnt & mask) == '0) && (tbl_q.size() < TABLE_DEPTH))
				tbl_q.push_back('{tag: tag, pc: pc, start: req_cnt});
			req_cnt++;
		end
		if (pop_do)
			void'(rec_q.pop_front());
	endtask

	// drive one cycle and advance the model
	// --------------------------------------------------
	task automatic step(input logic r, input logic [31:0] pc,
			input logic [TAG_W-1:0] tag, input logic [2:0] evt);
		@(posedge clock);
		comm                   <= cur_comm;
		req                    <= r;
		pc_ref                 <= pc;
		tag_ref                <= tag;
		{writeback, miss, hit} <= evt;
		model_edge(r, pc, tag, evt);
	endtask

	task automatic idle();
		step(1'b0, '0, '0, 3'b000);
	endtask

	task automatic send_req(input logic [TAG_W-1:0] tag);
		logic [31:0] bits;
		take_bits(8, bits);
		step(1'b1, 32'h0000_4000 + (bits << 2), tag, 3'b000);	// word aligned pc
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	// select, two edges, then read the return word
	task automatic read_check(input sel_e sel);
		logic [31:0] exp;
		cur_comm.sel = sel;
		idle();
		exp = expected_word(sel);
		idle();
		@(posedge clock);
		@(negedge clock);	// mid cycle, outputs settled
		check_value($sformatf("comm_o[%s]", sel.name()), comm_o, exp);
		check_value("stall_o", stall_o, model_stall());
	endtask

	task automatic pop_head();
		read_check(SEL_REFPC);
		read_check(SEL_TARGET);
		read_check(SEL_INTERVAL);
		read_check(SEL_TRACE_LO);
		read_check(SEL_TRACE_HI);
		cur_comm.pop = 1'b1;	// rising edge drops the head
		idle();
		cur_comm.pop = 1'b0;
		idle();
	endtask

	task automatic drain();
		while (rec_q.size() != 0)
			pop_head();
	endtask

	task automatic timeout_fail(input string what);
		$display("timeout while waiting for %s", what);
		$display("checks %0d, errors %0d", checks, errors);
		$display("CHECKS FAILED");
		$finish;
	endtask

	initial begin
		logic [31:0] bits;
		int          tries;
		comm       = '0;
		req        = 1'b0;
		pc_ref     = '0;
		tag_ref    = '0;
		hit        = 1'b0;
		miss       = 1'b0;
		writeback  = 1'b0;
		cur_comm   = '0;
		model_cnt  = '{default: '0};
		req_cnt    = '0;
		pop_q      = 1'b0;
		lfsr_state = 32'h56a047d2;
		errors     = 0;
		checks     = 0;
		tries      = 0;
		while (resetn !== 1'b1) begin
			@(negedge clock);
			if (++tries > 20) timeout_fail("reset release");
		end

		// reset state
		// --------------------------------------------------
		for (int s = 0; s < 16; s++)
			read_check(sel_e'(s));

		// event counters, enable toggled at random
		for (int i = 0; i < 160; i++) begin
			if (i % 16 == 0) begin
				take_bits(1, bits);
				cur_comm.count_en = bits[0];
			end
			take_bits(3, bits);
			step(1'b0, '0, '0, bits[2:0]);
		end
		for (int s = 0; s < 6; s++)
			read_check(sel_e'(s));
		cur_comm.count_en = 1'b0;

		// reuse intervals, every request sampled, three tags keep the table open
		// --------------------------------------------------
		for (int i = 0; i < 30; i++) begin
			take_bits(2, bits);
			send_req(TAG_W'(20'h00a00 + bits % 3));
			drain();
		end

		// sampling shift of two
		cur_comm.shift = 4'd2;
		for (int i = 0; i < 24; i++) begin
			take_bits(2, bits);
			send_req(TAG_W'(20'h00a00 + bits % 3));
			read_check(SEL_REMAINING);
			read_check(SEL_COUNT);
			drain();
		end

		// back-pressure from a full record buffer
		// --------------------------------------------------
		cur_comm.shift = 4'd0;
		tries          = 0;
		@(negedge clock);
		while (stall_o !== 1'b1) begin
			send_req(20'h00a01);	// same tag, every request a reuse
			@(negedge clock);
			if (++tries > 4 * BUF_DEPTH) timeout_fail("buffer full stall");
		end
		read_check(SEL_BUF_FULL);
		read_check(SEL_COUNT);
		send_req(20'h00a02);	// held off, not counted
		read_check(SEL_COUNT);
		pop_head();
		pop_head();
		tries = 0;
		@(negedge clock);
		while (stall_o !== 1'b0) begin
			idle();
			@(negedge clock);
			if (++tries > 8) timeout_fail("stall release after pops");
		end
		drain();

		// table full, close the old entries first
		// --------------------------------------------------
		cur_comm.shift = 4'd15;	// reuse without reinstall
		for (int t = 0; t < 3; t++)
			send_req(TAG_W'(20'h00a00 + t));
		drain();
		read_check(SEL_REMAINING);
		cur_comm.shift = 4'd0;
		tries          = 0;
		while (stall_o !== 1'b1) begin
			send_req(TAG_W'(20'h80000 + tries));	// distinct tags
			@(negedge clock);
			if (++tries > 2 * TABLE_DEPTH) timeout_fail("table full stall");
		end
		read_check(SEL_REMAINING);
		read_check(SEL_BUF_FULL);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: build.f
design/cache_perf_pkg.sv
design/reuse_interval_sampler.sv
design/cache_perf_controller.sv
design/cache_monitor_top.sv
tests/tb_clock_gen.sv
tests/cache_monitor_sva.sv
tests/cache_monitor_tb.sv

// File: Bender.yml
package:
  name: cache_monitor

sources:
  # design, in compile order
  - design/cache_perf_pkg.sv
  - design/reuse_interval_sampler.sv
  - design/cache_perf_controller.sv
  - design/cache_monitor_top.sv

  # testbench
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/cache_monitor_sva.sv
      - tests/cache_monitor_tb.sv
